// File: design/soc_config.svh
/*
 * Subsystem build parameters
 * Bus widths, data RAM depth and UART bit timing
 */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// AHB-Lite bus
`define AHB_ADDR_W        32
`define AHB_DATA_W        32

// Data RAM, word address bits (1024 words)
`define RAM_ADDR_W        10

// UART frame timing
`define UART_CLKS_PER_BIT 16   // Short bit time keeps simulation fast
`define UART_DATA_BITS    8

`endif

// File: design/soc_pkg.sv
/*
 * Shared types of the peripheral subsystem
 * AHB-Lite encodings, address regions and UART register map
 */
package soc_pkg;

`include "soc_config.svh"

    typedef enum logic [1:0] {IDLE = 2'b00, BUSY = 2'b01, NONSEQ = 2'b10, SEQ = 2'b11} htrans_e;

    typedef enum logic [2:0] {BYTE = 3'b000, HALF = 3'b001, WORD = 3'b010} hsize_e;

    // Top nibble of the address, anything else is unmapped
    typedef enum logic [3:0] {REGION_RAM = 4'h0, REGION_UART = 4'h1, REGION_NONE = 4'hf} region_e;

    typedef enum logic [2:0] {UART_DATA = 3'h0, UART_STATUS = 3'h4} uart_reg_e;

    typedef union packed {
        logic [`AHB_ADDR_W-1:0] raw;
        struct packed {
            region_e                  region;
            logic [`AHB_ADDR_W-5:0]   offset;
        } f;
    } ahb_addr_u;

endpackage

// File: design/ahb_slave_if.sv
/*
 * AHB-Lite signals of one slave port
 * Fabric side drives the address phase, slave returns ready and data
 */
`timescale 1ns/100ps
`include "soc_config.svh"

interface ahb_slave_if;

    logic                       hsel;
    logic [`AHB_ADDR_W-1:0]     haddr;
    soc_pkg::htrans_e           htrans;
    logic                       hwrite;
    soc_pkg::hsize_e            hsize;
    logic [`AHB_DATA_W-1:0]     hwdata;
    logic                       hready;     // Bus-wide ready
    logic                       hreadyout;  // This slave's ready
    logic [`AHB_DATA_W-1:0]     hrdata;

    modport fabric (output hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
                    input  hreadyout, hrdata);

    modport slave  (input  hsel, haddr, htrans, hwrite, hsize, hwdata, hready,
                    output hreadyout, hrdata);

endinterface

// File: design/ahb_decoder.sv
/*
 * AHB-Lite region decoder
 * Selects RAM or UART from the top address nibble and returns
 * the data-phase slave's ready and read data to the master
 */
`timescale 1ns/100ps
`include "soc_config.svh"

module ahb_decoder
(
    input  logic                    clk,
    input  logic                    RSTn,
    input  logic [`AHB_ADDR_W-1:0]  i_haddr,
    input  soc_pkg::htrans_e        i_htrans,
    input  logic                    i_hwrite,
    input  soc_pkg::hsize_e         i_hsize,
    input  logic [`AHB_DATA_W-1:0]  i_hwdata,
    output logic [`AHB_DATA_W-1:0]  o_hrdata,
    output logic                    o_hready,
    ahb_slave_if.fabric             ram_bus,
    ahb_slave_if.fabric             uart_bus
);
    import soc_pkg::*;

    ahb_addr_u  addr_u;
    region_e    data_region;    // Slave owning the current data phase
    logic       xfer_valid;

    assign addr_u     = i_haddr;
    assign xfer_valid = o_hready && (i_htrans == NONSEQ || i_htrans == SEQ);

    // ------------------------------------------------------------------
    // Address phase fan-out
    // ------------------------------------------------------------------
    assign ram_bus.hsel   = (addr_u.f.region == REGION_RAM);
    assign ram_bus.haddr  = i_haddr;
    assign ram_bus.htrans = i_htrans;
    assign ram_bus.hwrite = i_hwrite;
    assign ram_bus.hsize  = i_hsize;
    assign ram_bus.hwdata = i_hwdata;
    assign ram_bus.hready = o_hready;

    assign uart_bus.hsel   = (addr_u.f.region == REGION_UART);
    assign uart_bus.haddr  = i_haddr;
    assign uart_bus.htrans = i_htrans;
    assign uart_bus.hwrite = i_hwrite;
    assign uart_bus.hsize  = i_hsize;
    assign uart_bus.hwdata = i_hwdata;
    assign uart_bus.hready = o_hready;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            data_region <= REGION_NONE;
        else if (o_hready)
            data_region <= xfer_valid ? addr_u.f.region : REGION_NONE;
    end

    // ------------------------------------------------------------------
    // Data phase response mux
    // ------------------------------------------------------------------
    always_comb
    begin
        case (data_region)
            REGION_RAM:
            begin
                o_hready = ram_bus.hreadyout;
                o_hrdata = ram_bus.hrdata;
            end
            REGION_UART:
            begin
                o_hready = uart_bus.hreadyout;
                o_hrdata = uart_bus.hrdata;
            end
            default:
            begin
                o_hready = 1'b1;   // Unmapped, always OKAY
                o_hrdata = '0;
            end
        endcase
    end

endmodule

// File: design/ahb_ram.sv
/*
 * AHB-Lite data RAM, zero wait states
 * Word memory with byte lane writes and synchronous read
 */
`timescale 1ns/100ps
`include "soc_config.svh"

module ahb_ram
(
    input  logic        clk,
    input  logic        RSTn,
    ahb_slave_if.slave  bus
);
    import soc_pkg::*;

    localparam int LANES = `AHB_DATA_W / 8;

    logic [`AHB_DATA_W-1:0] mem [0:(1 << `RAM_ADDR_W)-1];
    logic [`RAM_ADDR_W-1:0] a_idx, d_idx;
    logic [LANES-1:0]       a_lanes, d_lanes;
    logic [LANES-1:0]       byp_lanes;      // Lanes written under a pending read
    logic [`AHB_DATA_W-1:0] byp_data;
    logic [`AHB_DATA_W-1:0] rd_q;
    logic                   a_valid, d_write, wr_commit;

    assign a_valid   = bus.hsel && bus.hready && (bus.htrans == NONSEQ || bus.htrans == SEQ);
    assign a_idx     = bus.haddr[`RAM_ADDR_W+1:2];
    assign wr_commit = d_write && bus.hready;

    always_comb
    begin
        case (bus.hsize)
            BYTE:    a_lanes = LANES'(1) << bus.haddr[1:0];
            HALF:    a_lanes = LANES'(3) << {bus.haddr[1], 1'b0};
            default: a_lanes = '1;
        endcase
    end

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            d_write   <= 1'b0;
            d_idx     <= '0;
            d_lanes   <= '0;
            byp_lanes <= '0;
        end
        else
        begin
            if (bus.hready)
                d_write <= a_valid && bus.hwrite;
            if (a_valid)
            begin
                d_idx     <= a_idx;
                d_lanes   <= a_lanes;
                byp_lanes <= (wr_commit && a_idx == d_idx) ? d_lanes : '0;
            end
        end
    end

    // Memory array and read port
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < LANES; i++)
            if (wr_commit && d_lanes[i])
                mem[d_idx][8*i +: 8] <= bus.hwdata[8*i +: 8];
        if (a_valid)
        begin
            rd_q     <= mem[a_idx];
            byp_data <= bus.hwdata;
        end
    end

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
            bus.hrdata[8*i +: 8] = byp_lanes[i] ? byp_data[8*i +: 8] : rd_q[8*i +: 8];
    end

    assign bus.hreadyout = 1'b1;

endmodule

// File: design/uart_core.sv
/*
 * 8N1 UART transmitter and receiver
 * Each direction runs its own bit timer
 */
`timescale 1ns/100ps
`include "soc_config.svh"

module uart_core
(
    input  logic                        clk,
    input  logic                        RSTn,
    input  logic [`UART_DATA_BITS-1:0]  i_tx_data,
    input  logic                        i_tx_start,
    input  logic                        i_rxd,
    input  logic                        i_rx_ack,
    output logic                        o_tx_busy,
    output logic                        o_txd,
    output logic [`UART_DATA_BITS-1:0]  o_rx_data,
    output logic                        o_rx_valid
);
    localparam int CLKS   = `UART_CLKS_PER_BIT;
    localparam int FRAME  = `UART_DATA_BITS + 2;   // Start, data, stop
    localparam int CNT_W  = $clog2(CLKS);
    localparam int BIT_W  = $clog2(FRAME);

    logic [FRAME-1:0]           tx_shift;
    logic [CNT_W-1:0]           tx_timer, rx_timer;
    logic [BIT_W-1:0]           tx_bits, rx_bits;
    logic [2:0]                 rx_sync;            // Two sync flops, then edge flop
    logic                       rx_active;
    logic [`UART_DATA_BITS-1:0] rx_shift;

    // ------------------------------------------------------------------
    // Transmitter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            tx_shift  <= '1;    // Line idles high
            tx_timer  <= '0;
            tx_bits   <= '0;
            o_tx_busy <= 1'b0;
        end
        else if (!o_tx_busy)
        begin
            if (i_tx_start)
            begin
                tx_shift  <= {1'b1, i_tx_data, 1'b0};
                tx_timer  <= '0;
                tx_bits   <= '0;
                o_tx_busy <= 1'b1;
            end
        end
        else if (tx_timer == CNT_W'(CLKS - 1))
        begin
            tx_timer <= '0;
            tx_shift <= {1'b1, tx_shift[FRAME-1:1]};
            if (tx_bits == BIT_W'(FRAME - 1))
                o_tx_busy <= 1'b0;
            else
                tx_bits <= tx_bits + 1'b1;
        end
        else
            tx_timer <= tx_timer + 1'b1;
    end

    assign o_txd = tx_shift[0];

    // ------------------------------------------------------------------
    // Receiver
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rx_sync    <= '1;
            rx_active  <= 1'b0;
            rx_timer   <= '0;
            rx_bits    <= '0;
            rx_shift   <= '0;
            o_rx_data  <= '0;
            o_rx_valid <= 1'b0;
        end
        else
        begin
            rx_sync <= {rx_sync[1:0], i_rxd};
            if (i_rx_ack)
                o_rx_valid <= 1'b0;
            if (!rx_active)
            begin
                if (rx_sync[2] && !rx_sync[1])  // Falling edge, start bit
                begin
                    rx_active <= 1'b1;
                    rx_timer  <= CNT_W'(CLKS / 2);  // First sample at mid start bit
                    rx_bits   <= '0;
                end
            end
            else if (rx_timer == CNT_W'(CLKS - 1))
            begin
                rx_timer <= '0;
                rx_bits  <= rx_bits + 1'b1;
                if (rx_bits == '0 && rx_sync[1])
                    rx_active <= 1'b0;      // Glitch, not a start bit
                else if (rx_bits == BIT_W'(FRAME - 1))
                begin
                    rx_active <= 1'b0;
                    if (rx_sync[1])         // Good stop bit, overwrite unread byte
                    begin
                        o_rx_data  <= rx_shift;
                        o_rx_valid <= 1'b1;
                    end
                end
                else if (rx_bits != '0)
                    rx_shift <= {rx_sync[1], rx_shift[`UART_DATA_BITS-1:1]};  // LSB first
            end
            else
                rx_timer <= rx_timer + 1'b1;
        end
    end

endmodule

// File: design/ahb_uart.sv
/*
 * AHB-Lite UART register front end
 * Data and status registers, stalls writes while transmitting
 */
`timescale 1ns/100ps
`include "soc_config.svh"

module ahb_uart
(
    input  logic        clk,
    input  logic        RSTn,
    ahb_slave_if.slave  bus,
    input  logic        i_rxd,
    output logic        o_txd,
    output logic        o_rx_valid
);
    import soc_pkg::*;

    logic [`UART_DATA_BITS-1:0] tx_data, rx_data;
    logic                       tx_busy, tx_start, rx_ack;
    logic                       a_valid, d_sel, d_write, data_wr;
    uart_reg_e                  d_reg;
    logic [`AHB_DATA_W-1:0]     rdata;

    assign a_valid = bus.hsel && bus.hready && (bus.htrans == NONSEQ || bus.htrans == SEQ);

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            d_sel   <= 1'b0;
            d_write <= 1'b0;
            d_reg   <= UART_DATA;
        end
        else if (bus.hready)
        begin
            d_sel   <= a_valid;
            d_write <= bus.hwrite;
            d_reg   <= uart_reg_e'(bus.haddr[2:0]);
        end
    end

    // Transmit write holds the bus until the frame in flight is done
    assign data_wr       = d_sel && d_write && (d_reg == UART_DATA);
    assign bus.hreadyout = !(data_wr && tx_busy);
    assign tx_start      = data_wr && !tx_busy;
    assign tx_data       = bus.hwdata[`UART_DATA_BITS-1:0];
    assign rx_ack        = d_sel && !d_write && (d_reg == UART_DATA);

    always_comb
    begin
        rdata = '0;
        if (d_sel && !d_write)
            case (d_reg)
                UART_DATA:   rdata[`UART_DATA_BITS-1:0] = rx_data;
                UART_STATUS: rdata[1:0] = {o_rx_valid, tx_busy};
                default:     rdata = '0;
            endcase
    end

    assign bus.hrdata = rdata;

    uart_core u_core
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_tx_data  (tx_data),
        .i_tx_start (tx_start),
        .i_rxd      (i_rxd),
        .i_rx_ack   (rx_ack),
        .o_tx_busy  (tx_busy),
        .o_txd      (o_txd),
        .o_rx_data  (rx_data),
        .o_rx_valid (o_rx_valid)
    );

endmodule

// File: design/soc_top.sv
/*
 * Peripheral subsystem top level
 * External AHB-Lite master port, data RAM and UART
 */
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_top
(
    input  logic                    clk,
    input  logic                    RSTn,
    input  logic [`AHB_ADDR_W-1:0]  i_haddr,
    input  soc_pkg::htrans_e        i_htrans,
    input  logic                    i_hwrite,
    input  soc_pkg::hsize_e         i_hsize,
    input  logic [`AHB_DATA_W-1:0]  i_hwdata,
    output logic [`AHB_DATA_W-1:0]  o_hrdata,
    output logic                    o_hready,
    output logic                    o_txd,
    input  logic                    i_rxd,
    output logic                    o_uart_irq
);

    ahb_slave_if ram_bus ();
    ahb_slave_if uart_bus ();

    ahb_decoder u_decoder
    (
        .clk      (clk),
        .RSTn     (RSTn),
        .i_haddr  (i_haddr),
        .i_htrans (i_htrans),
        .i_hwrite (i_hwrite),
        .i_hsize  (i_hsize),
        .i_hwdata (i_hwdata),
        .o_hrdata (o_hrdata),
        .o_hready (o_hready),
        .ram_bus  (ram_bus.fabric),
        .uart_bus (uart_bus.fabric)
    );

    ahb_ram u_ram (.clk(clk), .RSTn(RSTn), .bus(ram_bus.slave));

    // Receive valid doubles as the interrupt line
    ahb_uart u_uart
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .bus        (uart_bus.slave),
        .i_rxd      (i_rxd),
        .o_txd      (o_txd),
        .o_rx_valid (o_uart_irq)
    );

endmodule

// File: verification/soc_checker.sv
/*
 * Protocol assertions for the subsystem top level
 * Attached to soc_top by bind
 */
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_checker
(
    input  logic    clk,
    input  logic    RSTn,
    input  logic    i_hready,
    input  logic    i_txd,
    input  logic    i_irq,
    input  logic    i_tx_busy,
    input  logic    i_rx_ack
);
    localparam int STALL_MAX = 10 * `UART_CLKS_PER_BIT + 4;

    int         n_fail = 0;
    logic [8:0] stall_cnt;      // Cycles o_hready has been low

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            stall_cnt <= '0;
        else
            stall_cnt <= i_hready ? '0 : stall_cnt + 1'b1;
    end

    a_txd_idle: assert property (@(posedge clk) disable iff (!RSTn) !i_tx_busy |-> i_txd)
    else
    begin
        n_fail++;
        $error("o_txd low while the transmitter is idle");
    end

    a_ready_bound: assert property (@(posedge clk) disable iff (!RSTn) stall_cnt <= STALL_MAX)
    else
    begin
        n_fail++;
        $error("o_hready held low too long");
    end

    a_irq_clear: assert property (@(posedge clk) disable iff (!RSTn)
                                  (i_rx_ack && i_hready) |=> !i_irq)
    else
    begin
        n_fail++;
        $error("o_uart_irq still high after UART data read");
    end

endmodule

bind soc_top soc_checker u_chk
(
    .clk       (clk),
    .RSTn      (RSTn),
    .i_hready  (o_hready),
    .i_txd     (o_txd),
    .i_irq     (o_uart_irq),
    .i_tx_busy (u_uart.tx_busy),
    .i_rx_ack  (u_uart.rx_ack)
);

// File: verification/soc_monitor.sv
/*
 * Result monitor for the peripheral subsystem
 * Compares read data, stall behavior and serial frames
 */
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_monitor
(
    input  logic        clk,
    input  logic        RSTn,
    input  logic        i_hready,
    input  logic [31:0] i_hrdata,
    input  logic        i_txd,
    input  logic        i_irq,
    input  logic        i_chk_en,
    input  logic [1:0]  i_chk_kind,     // 1 read, 2 UART write, 3 UART write with stall
    input  logic [31:0] i_chk_exp,
    input  logic [31:0] i_chk_addr,
    input  logic        i_tx_push,
    input  logic [7:0]  i_tx_byte
);
    localparam int CLKS = `UART_CLKS_PER_BIT;

    int         n_pass = 0;
    int         n_fail = 0;
    int         stall  = 0;
    logic [7:0] exp_q [$];      // Bytes still owed on o_txd
    logic       push_d = 1'b0;
    logic       reset_seen = 1'b0;
    logic       txd_d = 1'b1;

    task automatic record_pass(input string msg);
        n_pass++;
        $display("%0t  ok     %s", $time, msg);
    endtask

    task automatic record_fail(input string msg);
        n_fail++;
        $display("%s (time %0t)", msg, $time);
    endtask

    // Bus side, sampled mid-cycle
    always @(negedge clk)
    begin
        if (!RSTn)
        begin
            stall      = 0;
            reset_seen = 1'b0;
        end
        else
        begin
            if (!reset_seen)
            begin
                reset_seen = 1'b1;
                if (i_hready === 1'b1 && i_txd === 1'b1 && i_irq === 1'b0)
                    record_pass("idle state after reset");
                else
                    record_fail($sformatf("reset state wrong: hready %b txd %b irq %b",
                                          i_hready, i_txd, i_irq));
            end
            if (i_tx_push && !push_d)
                exp_q.push_back(i_tx_byte);
            push_d = i_tx_push;
            if (i_chk_en && !i_hready)
                stall++;
            if (i_chk_en && i_hready)
            begin
                case (i_chk_kind)
                    2'd1:
                        if (i_hrdata !== i_chk_exp)
                            record_fail($sformatf("** Error o_hrdata: expected %h, got %h at %h",
                                                  i_chk_exp, i_hrdata, i_chk_addr));
                        else
                            record_pass($sformatf("read %h = %h", i_chk_addr, i_hrdata));
                    2'd2:
                        if (stall != 0)
                            record_fail("UART write stalled with the transmitter idle");
                        else
                            record_pass("UART write without wait states");
                    2'd3:
                        if (stall == 0)
                            record_fail("UART write did not wait for the frame in flight");
                        else
                            record_pass($sformatf("UART write held for %0d cycles", stall));
                    default: ;
                endcase
                stall = 0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Serial frame decoder
    // ------------------------------------------------------------------
    task automatic decode_frame;
        logic [7:0] bits;
        logic [7:0] expv;
        logic       stop_bit;
        int         n;
        repeat (CLKS / 2) @(negedge clk);   // Middle of start bit
        if (i_txd !== 1'b0)
        begin
            record_fail("start bit on o_txd shorter than half a bit");
            return;
        end
        for (int i = 0; i < 8; i++)
        begin
            repeat (CLKS) @(negedge clk);
            bits[i] = i_txd;                // LSB first
        end
        repeat (CLKS) @(negedge clk);
        stop_bit = i_txd;
        // Loopback receiver raises the interrupt near mid stop bit
        n = 0;
        while (i_irq !== 1'b1 && n < CLKS / 2)
        begin
            @(negedge clk);
            n++;
        end
        if (stop_bit !== 1'b1)
            record_fail("stop bit on o_txd not high");
        else if (exp_q.size() == 0)
            record_fail("frame on o_txd without a pending UART write");
        else
        begin
            expv = exp_q.pop_front();
            if (bits !== expv)
                record_fail($sformatf("** Error o_txd: expected %h, got %h", expv, bits));
            else if (i_irq !== 1'b1)
                record_fail("o_uart_irq did not rise after the looped-back frame");
            else
                record_pass($sformatf("frame %h on o_txd", bits));
        end
    endtask

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (RSTn && txd_d && !i_txd)
                decode_frame();
            txd_d = i_txd;
        end
    end

endmodule

// File: verification/tb_soc.sv
/*
 * Testbench top for the peripheral subsystem
 * Reads bus operations from the cases file, drives the AHB-Lite
 * master port and keeps a lane model of the data RAM
 */
`timescale 1ns/100ps
`include "soc_config.svh"

module tb_soc;
    import soc_pkg::*;

    localparam int READY_LIMIT = 10 * `UART_CLKS_PER_BIT + 40;
    localparam int POLL_LIMIT  = 200;

    logic                   clk;
    logic                   RSTn;
    logic [`AHB_ADDR_W-1:0] haddr;
    htrans_e                htrans;
    logic                   hwrite;
    hsize_e                 hsize;
    logic [`AHB_DATA_W-1:0] hwdata;
    logic [`AHB_DATA_W-1:0] hrdata;
    logic                   hready;
    logic                   txd;        // Looped back into i_rxd
    logic                   irq;

    // Monitor handoff
    logic                   chk_en;
    logic [1:0]             chk_kind;
    logic [31:0]            chk_exp;
    logic [31:0]            chk_addr;
    logic                   tx_push;
    logic [7:0]             tx_byte;

    logic [31:0]            shadow [int];   // RAM words written so far
    int                     n_err;
    bit                     aborted;

    soc_top dut
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_haddr    (haddr),
        .i_htrans   (htrans),
        .i_hwrite   (hwrite),
        .i_hsize    (hsize),
        .i_hwdata   (hwdata),
        .o_hrdata   (hrdata),
        .o_hready   (hready),
        .o_txd      (txd),
        .i_rxd      (txd),
        .o_uart_irq (irq)
    );

    soc_monitor mon
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_hready   (hready),
        .i_hrdata   (hrdata),
        .i_txd      (txd),
        .i_irq      (irq),
        .i_chk_en   (chk_en),
        .i_chk_kind (chk_kind),
        .i_chk_exp  (chk_exp),
        .i_chk_addr (chk_addr),
        .i_tx_push  (tx_push),
        .i_tx_byte  (tx_byte)
    );

    always #20 clk = ~clk;

    // ------------------------------------------------------------------
    // Bus driver
    // ------------------------------------------------------------------
    task automatic wait_ready(output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < READY_LIMIT)
        begin
            @(negedge clk);
            ok = hready;
            n++;
        end
        if (!ok)
            $display("Timeout: o_hready stayed low for %0d cycles", READY_LIMIT);
    endtask

    task automatic bus_xfer(input logic [31:0] addr, input bit write, input logic [2:0] size,
                            input logic [31:0] wdata, input logic [1:0] kind,
                            input logic [31:0] exp, output logic [31:0] rdata, output bit ok);
        @(posedge clk);
        haddr  <= addr;
        htrans <= NONSEQ;
        hwrite <= write;
        hsize  <= hsize_e'(size);
        wait_ready(ok);
        if (!ok)
            return;
        @(posedge clk);                 // Address accepted
        htrans   <= IDLE;
        hwdata   <= wdata;
        chk_en   <= 1'b1;
        chk_kind <= kind;
        chk_exp  <= exp;
        chk_addr <= addr;
        tx_push  <= (kind >= 2);
        tx_byte  <= wdata[7:0];
        wait_ready(ok);
        rdata = hrdata;
        if (!ok)
            return;
        @(posedge clk);                 // Data phase done
        chk_en  <= 1'b0;
        tx_push <= 1'b0;
    endtask

    // Merge a write into the RAM model by size and low address bits
    task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
                               input logic [31:0] data);
        logic [3:0]  lanes;
        logic [31:0] word;
        int          idx;
        idx = int'(addr[`RAM_ADDR_W+1:2]);
        case (size)
            3'd0:    lanes = 4'b0001 << addr[1:0];
            3'd1:    lanes = 4'b0011 << {addr[1], 1'b0};
            default: lanes = 4'b1111;
        endcase
        word = shadow.exists(idx) ? shadow[idx] : 32'h0;
        for (int i = 0; i < 4; i++)
            if (lanes[i])
                word[8*i +: 8] = data[8*i +: 8];
        shadow[idx] = word;
    endtask

    // ------------------------------------------------------------------
    // Case file sequencing
    // ------------------------------------------------------------------
    initial
    begin
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] addr, size, data, exp, rd;
        bit          ok, done;

        clk      = 1'b0;
        RSTn     = 1'b0;
        haddr    = '0;
        htrans   = IDLE;
        hwrite   = 1'b0;
        hsize    = WORD;
        hwdata   = '0;
        chk_en   = 1'b0;
        chk_kind = '0;
        chk_exp  = '0;
        chk_addr = '0;
        tx_push  = 1'b0;
        tx_byte  = '0;
        n_err    = 0;
        aborted  = 1'b0;

        repeat (8) @(posedge clk);
        RSTn <= 1'b1;
        repeat (2) @(posedge clk);

        fd = $fopen("verification/soc_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open verification/soc_cases.txt");
            aborted = 1'b1;
        end

        while (!aborted && $fgets(line, fd) > 0)
        begin
            ok = 1'b1;
            if ($sscanf(line, "%c %h %h %h %h", op, addr, size, data, exp) == 5)
            begin
                case (op)
                    "W":
                    begin
                        bus_xfer(addr, 1'b1, size[2:0], data, 2'd0, 32'h0, rd, ok);
                        if (ok && addr[31:28] == 4'h0)
                            model_write(addr, size[2:0], data);
                    end
                    "R":
                    begin
                        n = int'(addr[`RAM_ADDR_W+1:2]);
                        if (addr[31:28] == 4'h0 && shadow.exists(n) && shadow[n] !== exp)
                        begin
                            $display("Case file expects %h at %h but the lane model gives %h",
                                     exp, addr, shadow[n]);
                            n_err++;
                        end
                        bus_xfer(addr, 1'b0, size[2:0], 32'h0, 2'd1, exp, rd, ok);
                    end
                    "T":    // Expect column set means a stall is expected
                        bus_xfer(addr, 1'b1, size[2:0], data, (exp != 0) ? 2'd3 : 2'd2,
                                 32'h0, rd, ok);
                    "P":
                    begin
                        n    = 0;
                        done = 1'b0;
                        while (ok && !done && n < POLL_LIMIT)
                        begin
                            bus_xfer(addr, 1'b0, 3'd2, 32'h0, 2'd0, 32'h0, rd, ok);
                            done = ((rd & data) == exp);
                            n++;
                        end
                        if (ok && !done)
                        begin
                            $display("Timeout: status at %h never matched %h under mask %h",
                                     addr, exp, data);
                            ok = 1'b0;
                        end
                    end
                    default:
                        $display("Unknown operation in case file: %s", line);
                endcase
            end
            if (!ok)
                aborted = 1'b1;
        end
        if (fd != 0)
            $fclose(fd);

        repeat (4) @(posedge clk);
        if (mon.exp_q.size() != 0)
        begin
            $display("%0d transmitted bytes never appeared on o_txd", mon.exp_q.size());
            n_err++;
        end
        n = mon.n_fail + n_err + dut.u_chk.n_fail;
        $display("Summary: %0d passed, %0d failed", mon.n_pass, n);
        if (aborted || n != 0)
            $display("TESTS FAILED");
        else
            $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: verification/soc_cases.txt
# op addr size data expect, all hex, size 0 byte 1 half 2 word
# T: expect 1 means a stall is expected. P: poll until (status & data) == expect
W 00000010 2 12345678 0
R 00000010 2 00000000 12345678
W 00000011 0 0000ab00 0
R 00000010 2 00000000 1234ab78
W 00000012 1 cdef0000 0
R 00000010 2 00000000 cdefab78
W 00000020 2 a5a5a5a5 0
W 20000020 2 ffffffff 0
R 20000020 2 00000000 00000000
R 00000020 2 00000000 a5a5a5a5
T 10000000 2 0000005a 0
P 10000004 2 00000003 00000002
R 10000000 2 00000000 0000005a
R 10000004 2 00000000 00000000
T 10000000 2 000000c3 0
T 10000000 2 0000003c 1
P 10000004 2 00000003 00000002
R 10000000 2 00000000 0000003c

// File: src.f
+incdir+design
design/soc_pkg.sv
design/ahb_slave_if.sv
design/ahb_decoder.sv
design/ahb_ram.sv
design/uart_core.sv
design/ahb_uart.sv
design/soc_top.sv
verification/soc_checker.sv
verification/soc_monitor.sv
verification/tb_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f src.f -o tb_soc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
